//--- rtl/core_cfg_pkg.sv
package core_cfg_pkg;

    localparam int REG_W = 32;
    localparam int REG_COUNT = 16;
    localparam int INSN_DEPTH = 64;
    localparam int DATA_ADDR_W = 16;

    typedef logic [REG_W-1:0] reg_word_t;
    typedef logic [DATA_ADDR_W-1:0] mem_addr_t;

    typedef enum logic [1:0] {
        MEM_IDLE  = 2'd0,
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2
    } mem_enable_t;

    // operand source in execute
    typedef logic [1:0] fwd_sel_t;
    localparam fwd_sel_t FWD_REG = 2'd0;
    localparam fwd_sel_t FWD_MEM = 2'd1;
    localparam fwd_sel_t FWD_WB = 2'd2;

endpackage

//--- rtl/isa_pkg.sv
package isa_pkg;

    localparam int OPC_W = 4;
    localparam int REG_IDX_W = 4;
    localparam int CONST_W = 24;
    localparam int TARGET_W = 16;
    localparam int INSN_PTR_W = $clog2(core_cfg_pkg::INSN_DEPTH);

    typedef enum logic [OPC_W-1:0] {
        NOP       = 4'd0,
        READY     = 4'd1,
        ADD       = 4'd2,
        SUB       = 4'd3,
        MUL       = 4'd4,
        AND       = 4'd5,
        OR        = 4'd6,
        XOR       = 4'd7,
        LSHIFT    = 4'd8,
        RSHIFT    = 4'd9,
        CMPGE     = 4'd10,
        SET_CONST = 4'd11,
        LD        = 4'd12,
        ST        = 4'd13,
        BNZ       = 4'd14
    } opcode_t;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [INSN_PTR_W-1:0] insn_ptr_t;

    // opcode sits in the top nibble in every view
    typedef union packed {
        struct packed {
            opcode_t          opcode;
            reg_idx_t         dst;
            reg_idx_t         src0;
            reg_idx_t         src1;
            reg_idx_t         src2;
            logic [11:0]      unused;
        } reg_form;
        struct packed {
            opcode_t          opcode;
            reg_idx_t         dst;
            logic [CONST_W-1:0] value;
        } const_form;
        struct packed {
            opcode_t          opcode;
            reg_idx_t         src0;
            logic [7:0]       pad;
            logic [TARGET_W-1:0] target;
        } branch_form;
    } insn_word_t;

    localparam insn_word_t NOP_WORD = '0;
    localparam insn_word_t READY_WORD = insn_word_t'({READY, 28'd0});

    function automatic logic is_alu_op(opcode_t op);
        return op inside {ADD, SUB, MUL, AND, OR, XOR, LSHIFT, RSHIFT, CMPGE};
    endfunction

    function automatic logic is_mem_op(insn_word_t insn);
        return insn.reg_form.opcode inside {LD, ST};
    endfunction

    function automatic logic writes_reg(insn_word_t insn);
        return is_alu_op(insn.reg_form.opcode) || insn.reg_form.opcode inside {SET_CONST, LD};
    endfunction

    function automatic logic reads_src_a(insn_word_t insn);
        return is_alu_op(insn.reg_form.opcode) || insn.reg_form.opcode inside {LD, ST, BNZ};
    endfunction

    function automatic logic reads_src_b(insn_word_t insn);
        return is_alu_op(insn.reg_form.opcode) || insn.reg_form.opcode inside {LD, ST};
    endfunction

    // branch keeps its condition register where dst usually lives
    function automatic reg_idx_t src_a_idx(insn_word_t insn);
        return (insn.reg_form.opcode == BNZ) ? insn.branch_form.src0 : insn.reg_form.src0;
    endfunction

endpackage

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file
    import core_cfg_pkg::*;
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      init_en,
    input  reg_word_t init_data,
    input  reg_idx_t  rd_idx0,
    input  reg_idx_t  rd_idx1,
    input  reg_idx_t  rd_idx2,
    output reg_word_t rd_data0,
    output reg_word_t rd_data1,
    output reg_word_t rd_data2,
    input  logic      wr_en,
    input  reg_idx_t  wr_idx,
    input  reg_word_t wr_data
);

    reg_word_t regs [REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end
        else
        begin
            if (wr_en)
                regs[wr_idx] <= wr_data;
            if (init_en)
                regs[0] <= init_data; // seed wins over writeback
        end
    end

    assign rd_data0 = regs[rd_idx0];
    assign rd_data1 = regs[rd_idx1];
    assign rd_data2 = regs[rd_idx2];

endmodule

//--- rtl/insn_memory.sv
`timescale 1ns/1ps

module insn_memory
    import core_cfg_pkg::*;
    import isa_pkg::*;
(
    input  logic       clk,
    input  logic       wr_en,
    input  insn_ptr_t  wr_addr,
    input  insn_word_t wr_data,
    input  insn_ptr_t  rd_addr,
    output insn_word_t rd_data
);

    insn_word_t mem [INSN_DEPTH];

    // host side load port
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    assign rd_data = mem[rd_addr]; // fetch reads in the same cycle

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu
    import core_cfg_pkg::*;
    import isa_pkg::*;
(
    input  insn_word_t insn,
    input  reg_word_t  op_a,
    input  reg_word_t  op_b,
    output reg_word_t  result,
    output logic       nonzero
);

    always_comb
    begin
        case (insn.reg_form.opcode)
            ADD:
                result = op_a + op_b;
            SUB:
                result = op_a - op_b;
            MUL:
                result = op_a * op_b; // low word only
            AND:
                result = op_a & op_b;
            OR:
                result = op_a | op_b;
            XOR:
                result = op_a ^ op_b;
            LSHIFT:
                result = op_a << op_b[4:0];
            RSHIFT:
                result = op_a >> op_b[4:0];
            CMPGE:
                result = reg_word_t'(op_a >= op_b);
            SET_CONST:
                result = reg_word_t'(insn.const_form.value);
            LD, ST:
                result = op_a + op_b; // data address
            default:
                result = '0;
        endcase
    end

    // branch condition, only looked at for BNZ
    assign nonzero = (op_a != '0);

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
    import core_cfg_pkg::*;
    import isa_pkg::*;
(
    input  insn_word_t insn_d,
    input  insn_word_t insn_x,
    input  insn_word_t insn_m,
    input  insn_word_t insn_w,
    output logic       stall,
    output fwd_sel_t   fwd_a,
    output fwd_sel_t   fwd_b,
    output fwd_sel_t   fwd_c,
    output logic       fwd_m_addr,
    output logic       fwd_m_data
);

    logic x_is_load;
    logic w_is_load;
    logic x_store;
    reg_idx_t load_dst;

    // youngest writer wins, loads in memory never forward
    function automatic fwd_sel_t select_source(logic used, reg_idx_t idx,
                                               insn_word_t older_m, insn_word_t older_w);
        fwd_sel_t sel;
        sel = FWD_REG;
        if (used && writes_reg(older_m) && older_m.reg_form.opcode != LD
                && older_m.reg_form.dst == idx)
            sel = FWD_MEM;
        else if (used && writes_reg(older_w) && older_w.reg_form.dst == idx)
            sel = FWD_WB;
        return sel;
    endfunction

    assign x_is_load = (insn_x.reg_form.opcode == LD);
    assign w_is_load = (insn_w.reg_form.opcode == LD);
    assign x_store = (insn_x.reg_form.opcode == ST);
    assign load_dst = insn_x.reg_form.dst;

    // LD/ST base and store data get patched one stage later
    assign stall = x_is_load
        && ((reads_src_a(insn_d) && !is_mem_op(insn_d) && src_a_idx(insn_d) == load_dst)
            || (reads_src_b(insn_d) && insn_d.reg_form.src1 == load_dst));

    assign fwd_a = select_source(reads_src_a(insn_x), src_a_idx(insn_x), insn_m, insn_w);
    assign fwd_b = select_source(reads_src_b(insn_x), insn_x.reg_form.src1, insn_m, insn_w);
    assign fwd_c = select_source(x_store, insn_x.reg_form.src2, insn_m, insn_w);

    assign fwd_m_addr = is_mem_op(insn_m) && w_is_load
        && insn_w.reg_form.dst == insn_m.reg_form.src0;
    assign fwd_m_data = insn_m.reg_form.opcode == ST && w_is_load
        && insn_w.reg_form.dst == insn_m.reg_form.src2;

endmodule

//--- rtl/core.sv
`timescale 1ns/1ps

module core
    import core_cfg_pkg::*;
    import isa_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        load_en,
    input  insn_ptr_t   load_addr,
    input  insn_word_t  load_insn,
    input  logic        start,
    input  logic        init_r0,
    input  reg_word_t   init_r0_data,
    output logic        ready,
    input  reg_word_t   mem_rdata,
    input  logic        mem_ready,
    output reg_word_t   mem_wdata,
    output mem_addr_t   mem_addr,
    output mem_enable_t mem_enable
);

    localparam insn_ptr_t LAST_SLOT = insn_ptr_t'(INSN_DEPTH - 1);

    logic ready_r;
    logic past_end;
    insn_ptr_t fetch_ptr;
    insn_word_t mem_insn;
    insn_word_t insn_f;
    insn_word_t insn_d;
    insn_word_t insn_x;
    insn_word_t insn_m;
    insn_word_t insn_w;

    reg_word_t rf_data0;
    reg_word_t rf_data1;
    reg_word_t rf_data2;
    reg_word_t d_op_a;
    reg_word_t d_op_b;
    reg_word_t d_op_c;
    reg_word_t dx_a;
    reg_word_t dx_b;
    reg_word_t dx_c;
    reg_word_t x_op_a;
    reg_word_t x_op_b;
    reg_word_t x_op_c;
    reg_word_t x_result;
    logic x_nonzero;
    reg_word_t xm_result;
    reg_word_t xm_b;
    reg_word_t xm_c;
    reg_word_t mw_result;
    reg_word_t mw_load;
    reg_word_t w_result;
    reg_word_t m_addr_word;

    logic stall;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    fwd_sel_t fwd_c;
    logic fwd_m_addr;
    logic fwd_m_data;
    logic start_go;
    logic halt;
    logic freeze;
    logic advance;
    logic taken;
    logic wr_en;

    function automatic reg_word_t fwd_value(fwd_sel_t sel, reg_word_t reg_val,
                                            reg_word_t mem_val, reg_word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign ready = ready_r;
    assign start_go = start && ready_r;
    assign halt = (insn_m.reg_form.opcode == READY);
    assign freeze = is_mem_op(insn_m) && !mem_ready; // waiting on the data port
    assign advance = !ready_r && !freeze;
    assign taken = (insn_x.branch_form.opcode == BNZ) && x_nonzero;
    assign wr_en = advance && writes_reg(insn_w);

    assign insn_f = past_end ? READY_WORD : mem_insn;

    insn_memory insn_mem_i (
        .clk     (clk),
        .wr_en   (load_en && ready_r),
        .wr_addr (load_addr),
        .wr_data (load_insn),
        .rd_addr (fetch_ptr),
        .rd_data (mem_insn)
    );

    register_file regs_i (
        .clk       (clk),
        .reset     (reset),
        .init_en   (start_go && init_r0),
        .init_data (init_r0_data),
        .rd_idx0   (src_a_idx(insn_d)),
        .rd_idx1   (insn_d.reg_form.src1),
        .rd_idx2   (insn_d.reg_form.src2),
        .rd_data0  (rf_data0),
        .rd_data1  (rf_data1),
        .rd_data2  (rf_data2),
        .wr_en     (wr_en),
        .wr_idx    (insn_w.reg_form.dst),
        .wr_data   (w_result)
    );

    hazard_unit hazard_i (
        .insn_d     (insn_d),
        .insn_x     (insn_x),
        .insn_m     (insn_m),
        .insn_w     (insn_w),
        .stall      (stall),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .fwd_c      (fwd_c),
        .fwd_m_addr (fwd_m_addr),
        .fwd_m_data (fwd_m_data)
    );

    // regfile returns the old value on a same-cycle write
    assign d_op_a = (wr_en && insn_w.reg_form.dst == src_a_idx(insn_d)) ? w_result : rf_data0;
    assign d_op_b = (wr_en && insn_w.reg_form.dst == insn_d.reg_form.src1) ? w_result : rf_data1;
    assign d_op_c = (wr_en && insn_w.reg_form.dst == insn_d.reg_form.src2) ? w_result : rf_data2;

    assign x_op_a = fwd_value(fwd_a, dx_a, xm_result, w_result);
    assign x_op_b = fwd_value(fwd_b, dx_b, xm_result, w_result);
    assign x_op_c = fwd_value(fwd_c, dx_c, xm_result, w_result);

    alu alu_i (
        .insn    (insn_x),
        .op_a    (x_op_a),
        .op_b    (x_op_b),
        .result  (x_result),
        .nonzero (x_nonzero)
    );

    // base register loaded by the previous insn
    assign m_addr_word = fwd_m_addr ? mw_load + xm_b : xm_result;
    assign mem_addr = m_addr_word[DATA_ADDR_W-1:0];
    assign mem_wdata = fwd_m_data ? mw_load : xm_c;

    always_comb
    begin
        case (insn_m.reg_form.opcode)
            LD:      mem_enable = MEM_READ;
            ST:      mem_enable = MEM_WRITE;
            default: mem_enable = MEM_IDLE;
        endcase
    end

    assign w_result = (insn_w.reg_form.opcode == LD) ? mw_load : mw_result;

    always_ff @(posedge clk)
    begin
        if (reset)
            ready_r <= 1'b1;
        else if (start_go)
            ready_r <= 1'b0;
        else if (!ready_r && halt)
            ready_r <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset || start_go)
        begin
            fetch_ptr <= '0;
            past_end <= 1'b0;
            insn_d <= NOP_WORD;
            insn_x <= NOP_WORD;
            insn_m <= NOP_WORD;
            insn_w <= NOP_WORD;
        end
        else if (advance)
        begin
            insn_w <= insn_m;
            if (halt)
                insn_m <= NOP_WORD; // younger ones stay parked until next start
            else
            begin
                insn_m <= insn_x;
                insn_x <= (stall || taken) ? NOP_WORD : insn_d;
                if (taken)
                begin
                    insn_d <= NOP_WORD;
                    fetch_ptr <= insn_x.branch_form.target[INSN_PTR_W-1:0];
                    past_end <= 1'b0;
                end
                else if (!stall)
                begin
                    insn_d <= insn_f;
                    if (fetch_ptr == LAST_SLOT)
                        past_end <= 1'b1; // READY from here on
                    else
                        fetch_ptr <= fetch_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            dx_a <= d_op_a;
            dx_b <= d_op_b;
            dx_c <= d_op_c;
            xm_result <= x_result;
            xm_b <= x_op_b;
            xm_c <= x_op_c;
            mw_result <= xm_result;
            if (insn_m.reg_form.opcode == LD)
                mw_load <= mem_rdata;
        end
    end

endmodule

//--- testbench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

//--- include/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic insn_word_t reg_insn(opcode_t op, reg_idx_t d, reg_idx_t s0,
                                        reg_idx_t s1, reg_idx_t s2);
    insn_word_t w;
    w = '0;
    w.reg_form.opcode = op;
    w.reg_form.dst = d;
    w.reg_form.src0 = s0;
    w.reg_form.src1 = s1;
    w.reg_form.src2 = s2;
    return w;
endfunction

function automatic insn_word_t const_insn(reg_idx_t d, logic [23:0] value);
    insn_word_t w;
    w = '0;
    w.const_form.opcode = SET_CONST;
    w.const_form.dst = d;
    w.const_form.value = value;
    return w;
endfunction

function automatic insn_word_t branch_insn(reg_idx_t cond, logic [15:0] target);
    insn_word_t w;
    w = '0;
    w.branch_form.opcode = BNZ;
    w.branch_form.src0 = cond;
    w.branch_form.target = target;
    return w;
endfunction

// every slot gets written, unused ones as NOP
task automatic load_program();
    budget += 70;
    for (int slot = 0; slot < 64; slot++)
    begin
        check_word("ready", reg_word_t'(ready), 32'd1); // core stays idle until start
        check_enable("mem_enable", mem_enable, MEM_IDLE);
        load_en = 1'b1;
        load_addr = insn_ptr_t'(slot);
        load_insn = (slot < prog.size()) ? prog[slot] : NOP_WORD;
        @(posedge clk);
        #1;
    end
    load_en = 1'b0;
endtask

`endif

//--- testbench/core_tb.sv
`timescale 1ns/1ps

module core_tb
    import core_cfg_pkg::*;
    import isa_pkg::*;
();

    logic clk;
    logic reset;
    logic load_en;
    insn_ptr_t load_addr;
    insn_word_t load_insn;
    logic start;
    logic init_r0;
    reg_word_t init_r0_data;
    logic ready;
    reg_word_t mem_rdata;
    logic mem_ready;
    reg_word_t mem_wdata;
    mem_addr_t mem_addr;
    mem_enable_t mem_enable;

    reg_word_t dmem [256];
    mem_addr_t store_addr [$];
    reg_word_t store_data [$];
    mem_addr_t exp_addr [$];
    reg_word_t exp_data [$];
    insn_word_t prog [$];
    int seed = 32'hdc5d3292;
    int wait_left = -1;
    int cycles = 0;
    int budget = 40; // reset and idle check

    clock_gen clock_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    core core_i (
        .clk          (clk),
        .reset        (reset),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_insn    (load_insn),
        .start        (start),
        .init_r0      (init_r0),
        .init_r0_data (init_r0_data),
        .ready        (ready),
        .mem_rdata    (mem_rdata),
        .mem_ready    (mem_ready),
        .mem_wdata    (mem_wdata),
        .mem_addr     (mem_addr),
        .mem_enable   (mem_enable)
    );

    `include "tb_programs.svh"

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, reg_word_t got, reg_word_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_addr(string name, mem_addr_t got, mem_addr_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_enable(string name, mem_enable_t got, mem_enable_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    // data memory with 0 to 3 wait cycles per access
    always @(posedge clk)
    begin
        if (mem_enable == MEM_WRITE && mem_ready)
        begin
            dmem[mem_addr[7:0]] = mem_wdata;
            store_addr.push_back(mem_addr);
            store_data.push_back(mem_wdata);
        end
        #1;
        mem_ready = 1'b0;
        if (mem_enable != MEM_IDLE)
        begin
            if (wait_left < 0)
                wait_left = int'({$random(seed)} % 4);
            if (wait_left == 0)
            begin
                mem_rdata = dmem[mem_addr[7:0]];
                mem_ready = 1'b1;
                wait_left = -1;
            end
            else
                wait_left--;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > budget)
            report_failure($sformatf("timeout after %0d cycles, ready never returned", cycles));
    end

    function automatic reg_word_t expect_alu(opcode_t op, reg_word_t a, reg_word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            MUL:     return a * b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            LSHIFT:  return a << b[4:0];
            RSHIFT:  return a >> b[4:0];
            CMPGE:   return (a >= b) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    task automatic expect_store(int addr, reg_word_t data);
        exp_addr.push_back(mem_addr_t'(addr));
        exp_data.push_back(data);
    endtask

    task automatic run_program(logic seed_r0, reg_word_t seed_data, logic disturb, int extra);
        budget += 50 + 6 * (prog.size() + extra);
        start = 1'b1;
        init_r0 = seed_r0;
        init_r0_data = seed_data;
        @(posedge clk);
        #1;
        start = 1'b0;
        init_r0 = 1'b0;
        check_word("ready", reg_word_t'(ready), 32'd0);
        if (disturb)
        begin
            // would replace the store in slot 4 if accepted
            load_insn = reg_insn(ST, 0, 0, 0, 0);
            load_addr = insn_ptr_t'(4);
            repeat (3)
            begin
                load_en = 1'b1;
                @(posedge clk);
                #1;
            end
            load_en = 1'b0;
        end
        while (!ready)
        begin
            @(posedge clk);
            #1;
        end
        check_enable("mem_enable", mem_enable, MEM_IDLE);
    endtask

    task automatic check_stores();
        if (store_addr.size() != exp_addr.size())
            report_failure($sformatf("wrong number of stores: saw %0d, expected %0d",
                                     store_addr.size(), exp_addr.size()));
        foreach (exp_addr[i])
        begin
            check_addr("mem_addr", store_addr[i], exp_addr[i]);
            check_word("mem_wdata", store_data[i], exp_data[i]);
        end
        store_addr = {};
        store_data = {};
        exp_addr = {};
        exp_data = {};
    endtask

    task automatic idle_after_reset();
        repeat (5)
        begin
            check_word("ready", reg_word_t'(ready), 32'd1);
            check_enable("mem_enable", mem_enable, MEM_IDLE);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic alu_ops();
        opcode_t ops [10];
        reg_word_t a;
        reg_word_t b;
        ops = '{ADD, SUB, MUL, AND, OR, XOR, LSHIFT, RSHIFT, CMPGE, CMPGE};
        a = 32'h0012_3456;
        b = 32'h0000_0013;
        prog = {};
        prog.push_back(const_insn(0, 24'd0));
        prog.push_back(const_insn(3, 24'h40));
        prog.push_back(const_insn(6, 24'd1));
        prog.push_back(const_insn(1, a[23:0]));
        prog.push_back(const_insn(2, b[23:0])); // first op reads it straight away
        for (int i = 0; i < 10; i++)
        begin
            if (i == 9)
                prog.push_back(reg_insn(ops[i], 4, 2, 1, 0)); // swapped compare
            else
                prog.push_back(reg_insn(ops[i], 4, 1, 2, 0));
            prog.push_back(reg_insn(ST, 0, 3, 0, 4));
            prog.push_back(reg_insn(ADD, 3, 3, 6, 0));
            expect_store(32'h40 + i, (i == 9) ? expect_alu(ops[i], b, a)
                                              : expect_alu(ops[i], a, b));
        end
        prog.push_back(READY_WORD);
        load_program();
        run_program(1'b0, '0, 1'b0, 0);
        check_stores();
    endtask

    task automatic load_use();
        reg_word_t m0;
        reg_word_t m2;
        m0 = $random(seed);
        m2 = $random(seed);
        dmem[8'h10] = m0;
        dmem[8'h11] = 32'h30; // used as an address
        dmem[8'h12] = m2;
        prog = {};
        prog.push_back(const_insn(0, 24'd0));
        prog.push_back(const_insn(1, 24'h10));
        prog.push_back(const_insn(5, 24'h20));
        prog.push_back(const_insn(7, 24'd1));
        prog.push_back(const_insn(9, 24'd2));
        prog.push_back(reg_insn(LD, 2, 1, 0, 0));
        prog.push_back(reg_insn(ADD, 3, 2, 2, 0));
        prog.push_back(reg_insn(ST, 0, 5, 0, 3));
        prog.push_back(reg_insn(LD, 6, 1, 7, 0));
        prog.push_back(reg_insn(ST, 0, 6, 0, 3));
        prog.push_back(reg_insn(LD, 8, 1, 9, 0));
        prog.push_back(reg_insn(ST, 0, 5, 7, 8));
        prog.push_back(READY_WORD);
        expect_store(32'h20, m0 + m0);
        expect_store(32'h30, m0 + m0);
        expect_store(32'h21, m2);
        load_program();
        run_program(1'b0, '0, 1'b0, 0);
        check_stores();
    endtask

    task automatic branch_loop();
        prog = {};
        prog.push_back(const_insn(0, 24'd0));
        prog.push_back(const_insn(1, 24'd5));
        prog.push_back(const_insn(2, 24'd0));
        prog.push_back(const_insn(3, 24'd1));
        prog.push_back(const_insn(4, 24'h50));
        prog.push_back(reg_insn(ADD, 2, 2, 1, 0)); // slot 5, loop top
        prog.push_back(reg_insn(SUB, 1, 1, 3, 0));
        prog.push_back(branch_insn(1, 16'd5));
        prog.push_back(reg_insn(ST, 0, 4, 0, 2));
        prog.push_back(reg_insn(ST, 0, 4, 3, 1));
        prog.push_back(READY_WORD);
        expect_store(32'h50, 32'd15); // 5+4+3+2+1
        expect_store(32'h51, 32'd0);
        load_program();
        run_program(1'b0, '0, 1'b0, 25);
        check_stores();
    endtask

    task automatic seed_restart();
        reg_word_t seed_val;
        seed_val = $random(seed);
        prog = {};
        prog.push_back(const_insn(1, 24'd1));
        prog.push_back(reg_insn(ADD, 2, 0, 1, 0));
        prog.push_back(const_insn(3, 24'h60));
        prog.push_back(const_insn(5, 24'd0));
        prog.push_back(reg_insn(ST, 0, 3, 5, 2));
        prog.push_back(READY_WORD);
        expect_store(32'h60, seed_val + 1);
        load_program();
        run_program(1'b1, seed_val, 1'b0, 0);
        check_stores();

        // second run, no reset in between
        prog = {};
        prog.push_back(const_insn(1, 24'd7));
        prog.push_back(const_insn(2, 24'd9));
        prog.push_back(reg_insn(MUL, 3, 1, 2, 0));
        prog.push_back(const_insn(4, 24'h61));
        prog.push_back(reg_insn(ST, 0, 4, 5, 3));
        prog.push_back(READY_WORD);
        expect_store(32'h61, 32'd63);
        load_program();
        run_program(1'b0, '0, 1'b1, 0);
        check_stores();
    endtask

    task automatic run_off_end();
        prog = {};
        prog.push_back(const_insn(0, 24'd0));
        prog.push_back(const_insn(1, 24'h70));
        prog.push_back(const_insn(2, 24'habc));
        prog.push_back(reg_insn(ST, 0, 1, 0, 2));
        expect_store(32'h70, 32'habc);
        load_program();
        run_program(1'b0, '0, 1'b0, 64);
        check_stores();
    endtask

    initial
    begin
        load_en = 1'b0;
        load_addr = '0;
        load_insn = NOP_WORD;
        start = 1'b0;
        init_r0 = 1'b0;
        init_r0_data = '0;
        mem_rdata = '0;
        mem_ready = 1'b0;
        foreach (dmem[i])
            dmem[i] = 32'hd000_0000 | i;
        @(negedge reset);
        @(posedge clk);
        #1;
        idle_after_reset();
        alu_ops();
        load_use();
        branch_loop();
        seed_restart();
        run_off_end();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
rtl/core_cfg_pkg.sv
rtl/isa_pkg.sv
rtl/register_file.sv
rtl/insn_memory.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/core.sv
testbench/clock_gen.sv
testbench/core_tb.sv

//--- Makefile
TOP = core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)
	verilator --lint-only -f sim.f --top-module core

sim:
	verilator --binary --timing -f sim.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
